//--- source/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data and instruction width
`define WORD_SIZE 16

// architectural registers
`define NUM_REGS 4

// first fetch address after reset
`define RESET_PC 16'h0000

`endif

//--- source/cpuTypes_pkg.sv
`include "cpu_macros.svh"

package cpuTypes_pkg;

    typedef logic [`WORD_SIZE-1:0] word_t;
    typedef logic [$clog2(`NUM_REGS)-1:0] regIdx_t;

    // instr[15:12]
    typedef enum logic [3:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_ADI   = 4'd4,
        OP_ORI   = 4'd5,
        OP_LHI   = 4'd6,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_JMP   = 4'd9,
        OP_RTYPE = 4'd15
    } opcode_e;

    // instr[5:0], only meaningful for OP_RTYPE
    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_NOT = 6'd4,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } func_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_NOT,
        ALU_PASSB,
        ALU_LHI
    } aluOp_e;

    typedef struct packed {
        aluOp_e  aluOp;
        logic    aluSrcImm;     // operand b from immediate
        logic    regWrite;
        regIdx_t dest;
        logic    memRead;
        logic    memWrite;
        logic    isBranch;
        logic    branchOnEqual; // beq when set, bne otherwise
        logic    isJump;
        logic    isWwd;
        logic    isHalt;
        logic    valid;         // also the stage valid bit
    } ctrl_t;

    typedef struct packed {
        ctrl_t   ctrl;
        word_t   pc;
        regIdx_t rs;
        regIdx_t rt;
        word_t   opA;
        word_t   opB;
        word_t   imm;
    } idEx_t;

    typedef struct packed {
        ctrl_t ctrl;
        word_t result;
    } exWb_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  write;
    } dmemReq_t;

    typedef enum logic {
        FWD_REGFILE,
        FWD_WRITEBACK
    } fwdSel_e;

endpackage

//--- source/registerFile.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module registerFile (
    input  logic                 clk,
    input  logic                 rstN,
    input  cpuTypes_pkg::regIdx_t rdAddrA,
    input  cpuTypes_pkg::regIdx_t rdAddrB,
    input  logic                 wrEn,
    input  cpuTypes_pkg::regIdx_t wrAddr,
    input  cpuTypes_pkg::word_t   wrData,
    output cpuTypes_pkg::word_t   rdDataA,
    output cpuTypes_pkg::word_t   rdDataB
);

    cpuTypes_pkg::word_t regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // write-through, a same-cycle write is visible to decode
    assign rdDataA = (wrEn && (wrAddr == rdAddrA)) ? wrData : regs[rdAddrA];
    assign rdDataB = (wrEn && (wrAddr == rdAddrB)) ? wrData : regs[rdAddrB];

endmodule

//--- source/controlUnit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module controlUnit (
    input  cpuTypes_pkg::word_t instr,
    output cpuTypes_pkg::ctrl_t ctrl
);

    cpuTypes_pkg::opcode_e opcode;
    cpuTypes_pkg::func_e   func;
    cpuTypes_pkg::regIdx_t rt;
    cpuTypes_pkg::regIdx_t rd;

    assign opcode = cpuTypes_pkg::opcode_e'(instr[`WORD_SIZE-1 -: 4]);
    assign func   = cpuTypes_pkg::func_e'(instr[5:0]);
    assign rt     = instr[9:8];
    assign rd     = instr[7:6];

    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = cpuTypes_pkg::ALU_ADD;
        ctrl.valid = 1'b1;
        case (opcode)
            cpuTypes_pkg::OP_BNE, cpuTypes_pkg::OP_BEQ: begin
                ctrl.aluOp         = cpuTypes_pkg::ALU_SUB;
                ctrl.isBranch      = 1'b1;
                ctrl.branchOnEqual = (opcode == cpuTypes_pkg::OP_BEQ);
            end
            cpuTypes_pkg::OP_ADI, cpuTypes_pkg::OP_ORI, cpuTypes_pkg::OP_LHI: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.dest      = rt;
                if (opcode == cpuTypes_pkg::OP_ORI) begin
                    ctrl.aluOp = cpuTypes_pkg::ALU_OR;
                end else if (opcode == cpuTypes_pkg::OP_LHI) begin
                    ctrl.aluOp = cpuTypes_pkg::ALU_LHI;
                end
            end
            cpuTypes_pkg::OP_LWD: begin
                ctrl.aluSrcImm = 1'b1; // address is rs + imm
                ctrl.regWrite  = 1'b1;
                ctrl.dest      = rt;
                ctrl.memRead   = 1'b1;
            end
            cpuTypes_pkg::OP_SWD: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.memWrite  = 1'b1;
            end
            cpuTypes_pkg::OP_JMP: begin
                ctrl.isJump = 1'b1;
            end
            cpuTypes_pkg::OP_RTYPE: begin
                ctrl.dest = rd;
                case (func)
                    cpuTypes_pkg::FN_ADD: ctrl.regWrite = 1'b1;
                    cpuTypes_pkg::FN_SUB: begin
                        ctrl.aluOp    = cpuTypes_pkg::ALU_SUB;
                        ctrl.regWrite = 1'b1;
                    end
                    cpuTypes_pkg::FN_AND: begin
                        ctrl.aluOp    = cpuTypes_pkg::ALU_AND;
                        ctrl.regWrite = 1'b1;
                    end
                    cpuTypes_pkg::FN_ORR: begin
                        ctrl.aluOp    = cpuTypes_pkg::ALU_OR;
                        ctrl.regWrite = 1'b1;
                    end
                    cpuTypes_pkg::FN_NOT: begin
                        ctrl.aluOp    = cpuTypes_pkg::ALU_NOT;
                        ctrl.regWrite = 1'b1;
                    end
                    cpuTypes_pkg::FN_WWD: begin
                        ctrl.aluOp = cpuTypes_pkg::ALU_PASSB; // rs arrives on port b
                        ctrl.isWwd = 1'b1;
                    end
                    cpuTypes_pkg::FN_HLT: ctrl.isHalt = 1'b1;
                    default: ctrl.valid = 1'b0;
                endcase
            end
            default: ctrl.valid = 1'b0;
        endcase
        if (!ctrl.valid) begin
            ctrl = '0; // unknown encoding becomes a bubble
        end
    end

endmodule

//--- source/alu.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module alu (
    input  cpuTypes_pkg::word_t  opA,
    input  cpuTypes_pkg::word_t  opB,
    input  cpuTypes_pkg::aluOp_e aluOp,
    output cpuTypes_pkg::word_t  result,
    output logic                 equal
);

    localparam int HALF = `WORD_SIZE / 2;

    always_comb begin
        case (aluOp)
            cpuTypes_pkg::ALU_ADD:   result = opA + opB;
            cpuTypes_pkg::ALU_SUB:   result = opA - opB;
            cpuTypes_pkg::ALU_AND:   result = opA & opB;
            cpuTypes_pkg::ALU_OR:    result = opA | opB;
            cpuTypes_pkg::ALU_NOT:   result = ~opA;
            cpuTypes_pkg::ALU_PASSB: result = opB;
            cpuTypes_pkg::ALU_LHI:   result = {opB[HALF-1:0], {HALF{1'b0}}}; // imm into high byte
            default:                 result = '0;
        endcase
    end

    // branch condition, operands are rs and rt
    assign equal = (opA == opB);

endmodule

//--- source/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
    input  cpuTypes_pkg::idEx_t   exStage,
    input  cpuTypes_pkg::exWb_t   wbStage,
    input  logic                  dmemValid,
    input  logic                  dmemReady,
    input  logic                  branchTaken,
    input  logic                  jumpInDecode,
    output logic                  stall,
    output logic                  flushFetch,
    output logic                  flushDecode,
    output cpuTypes_pkg::fwdSel_e fwdA,
    output cpuTypes_pkg::fwdSel_e fwdB
);

    logic wbWrites;

    assign wbWrites = wbStage.ctrl.valid && wbStage.ctrl.regWrite;

    // writeback result bypasses the stale decode-time operand
    always_comb begin
        fwdA = cpuTypes_pkg::FWD_REGFILE;
        fwdB = cpuTypes_pkg::FWD_REGFILE;
        if (wbWrites && (wbStage.ctrl.dest == exStage.rs)) begin
            fwdA = cpuTypes_pkg::FWD_WRITEBACK;
        end
        if (wbWrites && (wbStage.ctrl.dest == exStage.rt)) begin
            fwdB = cpuTypes_pkg::FWD_WRITEBACK;
        end
    end

    assign stall = dmemValid && !dmemReady; // memory handshake pending

    // branch squashes fetch and decode, jump only fetch
    assign flushFetch  = branchTaken || jumpInDecode;
    assign flushDecode = branchTaken;

endmodule

//--- source/datapath.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module datapath (
    input  logic                   clk,
    input  logic                   rstN,
    output cpuTypes_pkg::word_t    imemAddr,
    input  cpuTypes_pkg::word_t    imemData,
    output logic                   dmemValid,
    input  logic                   dmemReady,
    output cpuTypes_pkg::dmemReq_t dmemReq,
    input  cpuTypes_pkg::word_t    dmemRdata,
    output cpuTypes_pkg::word_t    outputPort,
    output logic                   outputValid,
    output cpuTypes_pkg::word_t    numInst,
    output logic                   halted
);

    typedef struct packed {
        cpuTypes_pkg::word_t pc;
        cpuTypes_pkg::word_t instr;
        logic                valid;
    } ifId_t;

    cpuTypes_pkg::word_t   pc, pcNext;
    ifId_t                 ifId, ifIdNext;
    cpuTypes_pkg::idEx_t   idEx, idExNext;
    cpuTypes_pkg::exWb_t   exWb, exWbNext;

    cpuTypes_pkg::ctrl_t   decCtrl;
    logic                  decValid;
    cpuTypes_pkg::regIdx_t decRs, decRt;
    cpuTypes_pkg::word_t   decImm, rdDataA, rdDataB, jumpTarget;
    logic                  jumpInDecode;

    cpuTypes_pkg::fwdSel_e fwdA, fwdB;
    cpuTypes_pkg::word_t   exOpA, exOpB, aluB, aluResult, branchTarget;
    logic                  aluEqual, branchTaken;
    logic                  stall, flushFetch, flushDecode;
    logic                  haltAhead, fetchStop, retire;

    assign imemAddr = pc;

    // decode
    controlUnit controlUnit_i (.instr(ifId.instr), .ctrl(decCtrl));

    assign decValid     = ifId.valid && decCtrl.valid;
    assign decRs        = ifId.instr[11:10];
    assign decRt        = decCtrl.isWwd ? decRs : ifId.instr[9:8]; // wwd reads rs on port b
    assign jumpInDecode = decValid && decCtrl.isJump;
    assign jumpTarget   = {ifId.pc[`WORD_SIZE-1 -: 4], ifId.instr[11:0]};

    // ori zero-extends, everything else sign-extends
    assign decImm = (ifId.instr[`WORD_SIZE-1 -: 4] == cpuTypes_pkg::OP_ORI) ?
                    {{(`WORD_SIZE-8){1'b0}}, ifId.instr[7:0]} :
                    {{(`WORD_SIZE-8){ifId.instr[7]}}, ifId.instr[7:0]};

    registerFile registerFile_i (
        .clk(clk), .rstN(rstN),
        .rdAddrA(decRs), .rdAddrB(decRt),
        .wrEn(exWb.ctrl.valid && exWb.ctrl.regWrite && !halted),
        .wrAddr(exWb.ctrl.dest), .wrData(exWb.result),
        .rdDataA(rdDataA), .rdDataB(rdDataB)
    );

    // execute and memory
    assign exOpA = (fwdA == cpuTypes_pkg::FWD_WRITEBACK) ? exWb.result : idEx.opA;
    assign exOpB = (fwdB == cpuTypes_pkg::FWD_WRITEBACK) ? exWb.result : idEx.opB;
    assign aluB  = idEx.ctrl.aluSrcImm ? idEx.imm : exOpB;

    alu alu_i (
        .opA(exOpA), .opB(aluB), .aluOp(idEx.ctrl.aluOp),
        .result(aluResult), .equal(aluEqual)
    );

    assign branchTarget = idEx.pc + `WORD_SIZE'(1) + idEx.imm;
    assign branchTaken  = idEx.ctrl.valid && idEx.ctrl.isBranch &&
                          (aluEqual == idEx.ctrl.branchOnEqual);

    assign dmemValid     = idEx.ctrl.valid && (idEx.ctrl.memRead || idEx.ctrl.memWrite) && !halted;
    assign dmemReq.addr  = aluResult;
    assign dmemReq.wdata = exOpB;
    assign dmemReq.write = idEx.ctrl.memWrite;

    hazardUnit hazardUnit_i (
        .exStage(idEx), .wbStage(exWb),
        .dmemValid(dmemValid), .dmemReady(dmemReady),
        .branchTaken(branchTaken), .jumpInDecode(jumpInDecode),
        .stall(stall), .flushFetch(flushFetch), .flushDecode(flushDecode),
        .fwdA(fwdA), .fwdB(fwdB)
    );

    // an hlt anywhere ahead stops fetch unless an older branch redirects
    assign haltAhead = (decValid && decCtrl.isHalt) ||
                       (idEx.ctrl.valid && idEx.ctrl.isHalt) ||
                       (exWb.ctrl.valid && exWb.ctrl.isHalt);
    assign fetchStop = haltAhead && !branchTaken;

    // writeback
    assign retire      = exWb.ctrl.valid && !halted;
    assign outputValid = retire && exWb.ctrl.isWwd;
    assign outputPort  = exWb.result;

    always_comb begin
        pcNext   = pc + `WORD_SIZE'(1);
        ifIdNext = '{pc: pc, instr: imemData, valid: 1'b1};
        idExNext = '{ctrl: decCtrl, pc: ifId.pc, rs: decRs, rt: decRt,
                     opA: rdDataA, opB: rdDataB, imm: decImm};
        idExNext.ctrl.valid = decValid;
        exWbNext = '{ctrl: idEx.ctrl, result: idEx.ctrl.memRead ? dmemRdata : aluResult};

        if (halted) begin
            pcNext   = pc;
            ifIdNext = ifId;
            idExNext = idEx;
            exWbNext = exWb;
        end else if (stall) begin
            pcNext   = pc;
            ifIdNext = ifId;
            idExNext = idEx;
            idExNext.opA = exOpA;        // capture bypass before wb drains
            idExNext.opB = exOpB;
            exWbNext.ctrl.valid = 1'b0;  // bubble while waiting
        end else begin
            if (branchTaken) begin
                pcNext = branchTarget;
            end else if (fetchStop) begin
                pcNext = pc;
            end else if (jumpInDecode) begin
                pcNext = jumpTarget;
            end
            if (flushFetch || fetchStop) begin
                ifIdNext.valid = 1'b0;
            end
            if (flushDecode) begin
                idExNext.ctrl.valid = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc                <= `RESET_PC;
            ifId.valid        <= 1'b0;
            idEx.ctrl.valid   <= 1'b0;
            exWb.ctrl.valid   <= 1'b0;
            numInst           <= '0;
            halted            <= 1'b0;
        end else begin
            pc   <= pcNext;
            ifId <= ifIdNext;
            idEx <= idExNext;
            exWb <= exWbNext;
            if (retire) begin
                numInst <= numInst + `WORD_SIZE'(1);
            end
            if (retire && exWb.ctrl.isHalt) begin
                halted <= 1'b1; // sticky until reset
            end
        end
    end

endmodule

//--- tests/datapath_checker.sv
`timescale 1ns/1ps

module datapath_checker (
    input logic                   clk,
    input logic                   rstN,
    input logic                   dmemValid,
    input logic                   dmemReady,
    input cpuTypes_pkg::dmemReq_t dmemReq,
    input logic                   outputValid,
    input logic                   halted,
    input cpuTypes_pkg::word_t    numInst,
    input logic                   fetchValid,
    input logic                   execValid,
    input logic                   wbValid
);

    // request is held until the memory accepts it
    assert property (@(posedge clk) disable iff (!rstN)
        dmemValid && !dmemReady |=> dmemValid && $stable(dmemReq))
        else $error("dmemReq changed while waiting for dmemReady");

    // a reset cycle leaves every stage empty
    assert property (@(posedge clk)
        !rstN |=> !(fetchValid || execValid || wbValid || dmemValid || outputValid || halted)
                  && (numInst == '0))
        else $error("core not idle after a reset cycle");

    assert property (@(posedge clk) disable iff (!rstN) halted |=> $stable(numInst))
        else $error("numInst changed while halted");

endmodule

bind datapath datapath_checker datapath_checker_i (
    .clk(clk), .rstN(rstN), .dmemValid(dmemValid), .dmemReady(dmemReady),
    .dmemReq(dmemReq), .outputValid(outputValid), .halted(halted), .numInst(numInst),
    .fetchValid(ifId.valid), .execValid(idEx.ctrl.valid), .wbValid(exWb.ctrl.valid)
);

//--- tests/datapath_tb.sv
`timescale 1ns/1ps

module datapath_tb;

    logic                   clk = 1'b0;
    logic                   rstN = 1'b0;
    logic                   dmemReady = 1'b0;
    logic                   dmemValid, outputValid, halted;
    cpuTypes_pkg::word_t    imemAddr, imemData, outputPort, numInst;
    cpuTypes_pkg::word_t    dmemRdata = '0;
    cpuTypes_pkg::dmemReq_t dmemReq;

    cpuTypes_pkg::word_t    imem [256];
    cpuTypes_pkg::word_t    dmem [256];
    cpuTypes_pkg::word_t    memModel [256]; // expected data memory
    cpuTypes_pkg::word_t    regModel [4];   // expected register contents
    cpuTypes_pkg::word_t    expWords [$];
    cpuTypes_pkg::word_t    gotWords [$];
    int progLen;
    int expCount;
    int errorsAtStart;
    int waitLeft = -1;
    int errorCount = 0;
    int testsPassed = 0;
    int testsFailed = 0;
    int seed = 85;
    int cycleBudget = 0;

    datapath datapath_i (.*);

    always #50 clk = ~clk;

    assign imemData = imem[imemAddr[7:0]]; // same-cycle fetch

    // data memory with 0 to 3 wait cycles per request
    always @(posedge clk) begin
        #1;
        if (dmemReady || !dmemValid) begin
            dmemReady = 1'b0;
            waitLeft  = -1;
        end
        if (dmemValid && waitLeft < 0) begin
            waitLeft = {$random(seed)} % 4;
        end
        if (waitLeft == 0) begin
            dmemReady = 1'b1;
            waitLeft  = -1;
            dmemRdata = dmem[dmemReq.addr[7:0]];
            if (dmemReq.write) begin
                dmem[dmemReq.addr[7:0]] = dmemReq.wdata; // accepted at the next edge
            end
        end else if (waitLeft > 0) begin
            waitLeft--;
        end
    end

    // budget grows by 20 cycles per loaded instruction
    initial begin
        int cycles;
        cycles = 0;
        while (cycles <= cycleBudget) begin
            @(posedge clk);
            cycles++;
        end
        $display("Watchdog expired after %0d cycles, the core did not halt in time", cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic checkWord(string what, cpuTypes_pkg::word_t got, cpuTypes_pkg::word_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkCount(cpuTypes_pkg::word_t got, cpuTypes_pkg::word_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: numInst is %0d, expected %0d", $time, got, exp);
            errorCount++;
        end
    endtask

    function automatic cpuTypes_pkg::word_t signExtend(logic [7:0] imm);
        return {{8{imm[7]}}, imm};
    endfunction

    task automatic clearProgram();
        for (int i = 0; i < 256; i++) begin
            imem[i]     = {8'h20, 8'(i)}; // opcode 2 is unused, so a bubble
            dmem[i]     = {8'(i), ~8'(i)};
            memModel[i] = dmem[i];
        end
        regModel      = '{default: '0};
        progLen       = 0;
        expCount      = 0;
        errorsAtStart = errorCount;
        expWords.delete();
    endtask

    task automatic place(cpuTypes_pkg::word_t instr, bit live);
        imem[progLen] = instr;
        progLen++;
        cycleBudget += 20;
        if (live) begin
            expCount++;
        end
    endtask

    // {op, rs, rt, imm8}, a jump reads rs, rt and imm as its 12-bit target
    task automatic immOp(cpuTypes_pkg::opcode_e op, int rs, int rt, logic [7:0] imm, bit live);
        cpuTypes_pkg::word_t addr;
        place({op, 2'(rs), 2'(rt), imm}, live);
        addr = regModel[rs] + signExtend(imm);
        if (live) begin
            case (op)
                cpuTypes_pkg::OP_ADI: regModel[rt] = addr;
                cpuTypes_pkg::OP_ORI: regModel[rt] = regModel[rs] | {8'h00, imm};
                cpuTypes_pkg::OP_LHI: regModel[rt] = {imm, 8'h00};
                cpuTypes_pkg::OP_LWD: regModel[rt] = memModel[addr[7:0]];
                cpuTypes_pkg::OP_SWD: memModel[addr[7:0]] = regModel[rt];
                default: ; // branches and jumps touch no register
            endcase
        end
    endtask

    task automatic regOp(cpuTypes_pkg::func_e fn, int rs, int rt, int rd, bit live);
        place({cpuTypes_pkg::OP_RTYPE, 2'(rs), 2'(rt), 2'(rd), fn}, live);
        if (live) begin
            case (fn)
                cpuTypes_pkg::FN_ADD: regModel[rd] = regModel[rs] + regModel[rt];
                cpuTypes_pkg::FN_SUB: regModel[rd] = regModel[rs] - regModel[rt];
                cpuTypes_pkg::FN_AND: regModel[rd] = regModel[rs] & regModel[rt];
                cpuTypes_pkg::FN_ORR: regModel[rd] = regModel[rs] | regModel[rt];
                cpuTypes_pkg::FN_NOT: regModel[rd] = ~regModel[rs];
                cpuTypes_pkg::FN_WWD: expWords.push_back(regModel[rs]);
                default: ;
            endcase
        end
    endtask

    task automatic runProgram();
        @(posedge clk);
        #1 rstN = 1'b0;
        repeat (8) @(posedge clk);
        #1 rstN = 1'b1;
        gotWords.delete();
        while (!halted) begin
            @(negedge clk);
            if (outputValid) begin
                gotWords.push_back(outputPort);
            end
        end
        checkCount(numInst, cpuTypes_pkg::word_t'(expCount));
        if (gotWords.size() != expWords.size()) begin
            $display("At %0t the core wrote %0d words to the output port instead of %0d",
                     $time, gotWords.size(), expWords.size());
            errorCount++;
        end else begin
            foreach (gotWords[i]) begin
                checkWord("output word", gotWords[i], expWords[i]);
            end
        end
    endtask

    task automatic checkMemory();
        for (int i = 0; i < 256; i++) begin
            checkWord($sformatf("dmem[%0d]", i), dmem[i], memModel[i]);
        end
    endtask

    task automatic reportTest(string name);
        if (errorCount == errorsAtStart) begin
            testsPassed++;
            $display("%s: ok", name);
        end else begin
            testsFailed++;
            $display("%s: %0d errors", name, errorCount - errorsAtStart);
        end
    endtask

    task automatic testAlu();
        clearProgram();
        immOp(cpuTypes_pkg::OP_ADI, 0, 1, 8'hF3, 1); // negative immediate
        regOp(cpuTypes_pkg::FN_WWD, 1, 0, 0, 1);
        immOp(cpuTypes_pkg::OP_ORI, 0, 2, 8'h80, 1); // zero-extended
        regOp(cpuTypes_pkg::FN_WWD, 2, 0, 0, 1);
        immOp(cpuTypes_pkg::OP_LHI, 0, 3, 8'hA5, 1);
        regOp(cpuTypes_pkg::FN_WWD, 3, 0, 0, 1);
        regOp(cpuTypes_pkg::FN_ADD, 1, 3, 0, 1);
        regOp(cpuTypes_pkg::FN_WWD, 0, 0, 0, 1);
        regOp(cpuTypes_pkg::FN_SUB, 3, 2, 2, 1);
        regOp(cpuTypes_pkg::FN_WWD, 2, 0, 0, 1);
        regOp(cpuTypes_pkg::FN_AND, 0, 3, 1, 1);
        regOp(cpuTypes_pkg::FN_WWD, 1, 0, 0, 1);
        regOp(cpuTypes_pkg::FN_ORR, 2, 1, 3, 1);
        regOp(cpuTypes_pkg::FN_WWD, 3, 0, 0, 1);
        regOp(cpuTypes_pkg::FN_NOT, 3, 0, 0, 1);
        regOp(cpuTypes_pkg::FN_WWD, 0, 0, 0, 1);
        regOp(cpuTypes_pkg::FN_HLT, 0, 0, 0, 1);
        runProgram();
        reportTest("alu and immediates");
    endtask

    task automatic testForward();
        clearProgram();
        immOp(cpuTypes_pkg::OP_ADI, 0, 1, 8'h03, 1);
        regOp(cpuTypes_pkg::FN_ADD, 1, 1, 2, 1);
        regOp(cpuTypes_pkg::FN_SUB, 2, 1, 3, 1);
        regOp(cpuTypes_pkg::FN_ADD, 3, 2, 1, 1);
        regOp(cpuTypes_pkg::FN_NOT, 1, 0, 1, 1);
        regOp(cpuTypes_pkg::FN_WWD, 1, 0, 0, 1);
        regOp(cpuTypes_pkg::FN_WWD, 2, 0, 0, 1);
        regOp(cpuTypes_pkg::FN_WWD, 3, 0, 0, 1);
        regOp(cpuTypes_pkg::FN_HLT, 0, 0, 0, 1);
        runProgram();
        reportTest("forwarding");
    endtask

    task automatic testMemory();
        clearProgram();
        immOp(cpuTypes_pkg::OP_ADI, 0, 1, 8'h10, 1);
        immOp(cpuTypes_pkg::OP_ADI, 0, 2, 8'h5A, 1);
        immOp(cpuTypes_pkg::OP_SWD, 1, 2, 8'h00, 1);
        immOp(cpuTypes_pkg::OP_SWD, 1, 1, 8'h01, 1);
        immOp(cpuTypes_pkg::OP_LWD, 1, 3, 8'h00, 1);
        regOp(cpuTypes_pkg::FN_WWD, 3, 0, 0, 1);
        immOp(cpuTypes_pkg::OP_LWD, 1, 0, 8'h01, 1);
        regOp(cpuTypes_pkg::FN_ADD, 0, 3, 0, 1);     // load-use
        regOp(cpuTypes_pkg::FN_WWD, 0, 0, 0, 1);
        immOp(cpuTypes_pkg::OP_LWD, 1, 2, 8'hFF, 1); // untouched fill word
        regOp(cpuTypes_pkg::FN_WWD, 2, 0, 0, 1);
        regOp(cpuTypes_pkg::FN_HLT, 0, 0, 0, 1);
        runProgram();
        checkMemory();
        reportTest("loads and stores");
    endtask

    task automatic testControl();
        clearProgram();
        immOp(cpuTypes_pkg::OP_ADI, 0, 1, 8'h01, 1);
        immOp(cpuTypes_pkg::OP_ADI, 0, 2, 8'h01, 1);
        immOp(cpuTypes_pkg::OP_BEQ, 1, 2, 8'h02, 1); // taken, to 5
        immOp(cpuTypes_pkg::OP_ADI, 3, 3, 8'h55, 0);
        regOp(cpuTypes_pkg::FN_WWD, 1, 0, 0, 0);
        immOp(cpuTypes_pkg::OP_BNE, 1, 2, 8'h02, 1); // not taken
        regOp(cpuTypes_pkg::FN_WWD, 1, 0, 0, 1);
        immOp(cpuTypes_pkg::OP_JMP, 0, 0, 8'h09, 1);
        immOp(cpuTypes_pkg::OP_ADI, 3, 3, 8'h66, 0);
        immOp(cpuTypes_pkg::OP_BNE, 1, 3, 8'h01, 1); // taken, to 11
        regOp(cpuTypes_pkg::FN_WWD, 1, 0, 0, 0);
        regOp(cpuTypes_pkg::FN_WWD, 3, 0, 0, 1);
        immOp(cpuTypes_pkg::OP_BEQ, 1, 3, 8'h01, 1); // not taken
        regOp(cpuTypes_pkg::FN_WWD, 2, 0, 0, 1);
        regOp(cpuTypes_pkg::FN_HLT, 0, 0, 0, 1);
        runProgram();
        reportTest("control flow");
    endtask

    task automatic testHalt();
        cpuTypes_pkg::word_t held;
        clearProgram();
        immOp(cpuTypes_pkg::OP_ADI, 0, 1, 8'h22, 1);
        immOp(cpuTypes_pkg::OP_SWD, 0, 1, 8'h03, 1);
        regOp(cpuTypes_pkg::FN_HLT, 0, 0, 0, 1);
        immOp(cpuTypes_pkg::OP_SWD, 0, 1, 8'h04, 0); // past the halt
        runProgram();
        held = numInst;
        repeat (20) begin
            @(negedge clk);
            checkCount(numInst, held);
            if (dmemValid || !halted) begin
                $display("At %0t the halted core left its halt state or requested memory", $time);
                errorCount++;
            end
        end
        checkMemory();
        reportTest("retire count and halt");
    endtask

    initial begin
        testAlu();
        testForward();
        testMemory();
        testControl();
        testHalt();
        $display("tests ok: %0d, tests with errors: %0d, total errors: %0d",
                 testsPassed, testsFailed, errorCount);
        if (errorCount == 0 && testsFailed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- datapath.f
+incdir+source
source/cpuTypes_pkg.sv
source/registerFile.sv
source/controlUnit.sv
source/alu.sv
source/hazardUnit.sv
source/datapath.sv
tests/datapath_checker.sv
tests/datapath_tb.sv

//--- run.sh
#!/bin/sh
# build the datapath testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f datapath.f --top-module datapath_tb \
    -o datapath_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/datapath_sim > sim.log 2>&1
grep -q "\*\*\* TEST FAILED \*\*\*" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "\*\*\* TEST PASSED \*\*\*" sim.log || { echo "run ended early, see sim.log"; exit 1; }
echo "simulation passed"
